// File: filelist.f
verilog/wbuf_pkg.sv
verilog/wbuf_alloc.sv
verilog/wbuf_entry.sv
verilog/wbuf_drain.sv
verilog/wbuf_rtrn_fifo.sv
verilog/wbuf_top.sv
verif/wbuf_checker.sv
verif/tb_wbuf.sv

// File: verif/tb_wbuf.sv
/* testbench of the write buffer, random core writes over a small word pool
   and a memory model that acks at random and returns ids after 1 to 20 cycles */
module tb_wbuf
  import wbuf_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned DEPTH  = 8;
  localparam int unsigned MAX_TX = 4;
  localparam int POOL            = 12;
  localparam int SILENT_HOLD     = 40;
  localparam int GNT_TIMEOUT     = 2000;
  localparam int REPORT_TIMEOUT  = 5000;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      wr_valid_i;
  wr_req_t   wr_req_i;
  logic      wr_gnt_o;
  logic      miss_req_o;
  miss_req_t miss_o;
  logic      miss_ack_i;
  logic      miss_rtrn_vld_i;
  tx_id_t    miss_rtrn_id_i;
  logic      empty_o;

  // memory stops acking while set
  logic      silent;
  logic      final_req;
  logic      report_done;
  int        fail_cnt;
  bit        aborted;
  string     why;

  always #20 clk_i = ~clk_i;

  wbuf_top #(
    .DEPTH (DEPTH),
    .MAX_TX(MAX_TX)
  ) i_wbuf_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_valid_i     (wr_valid_i),
    .wr_req_i       (wr_req_i),
    .wr_gnt_o       (wr_gnt_o),
    .miss_req_o     (miss_req_o),
    .miss_o         (miss_o),
    .miss_ack_i     (miss_ack_i),
    .miss_rtrn_vld_i(miss_rtrn_vld_i),
    .miss_rtrn_id_i (miss_rtrn_id_i),
    .empty_o        (empty_o)
  );

  wbuf_checker #(
    .DEPTH (DEPTH),
    .MAX_TX(MAX_TX)
  ) i_wbuf_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_valid_i     (wr_valid_i),
    .wr_req_i       (wr_req_i),
    .wr_gnt_i       (wr_gnt_o),
    .miss_req_i     (miss_req_o),
    .miss_i         (miss_o),
    .miss_ack_i     (miss_ack_i),
    .miss_rtrn_vld_i(miss_rtrn_vld_i),
    .miss_rtrn_id_i (miss_rtrn_id_i),
    .empty_i        (empty_o),
    .final_i        (final_req),
    .done_o         (report_done),
    .fail_cnt_o     (fail_cnt)
  );

  // spread the pool over unrelated address bits
  function automatic waddr_t pool_addr(int i);
    return waddr_t'(29'h0012_3400 + i * 29'h0000_0101);
  endfunction

  // request is held until granted, a long stall releases the silent memory
  task automatic write_word(input waddr_t addr);
    int waited;
    waited = 0;
    if (!aborted) begin
      wr_valid_i <= 1'b1;
      wr_req_i   <= '{waddr: addr, data: {$urandom, $urandom}, be: be_t'($urandom_range(255, 1))};
      @(posedge clk_i);
      while (!wr_gnt_o && waited < GNT_TIMEOUT) begin
        if (waited == SILENT_HOLD) silent <= 1'b0;
        waited++;
        @(posedge clk_i);
      end
      wr_valid_i <= 1'b0;
      if (!wr_gnt_o) begin
        aborted = 1'b1;
        why     = "a write request was never granted";
      end
    end
  endtask

  ////////////////////
  // memory responder
  ////////////////////

  initial begin : p_memory
    logic   pend_vld [MAX_TX];
    tx_id_t pend_id  [MAX_TX];
    int     pend_cnt [MAX_TX];
    int     pick;
    int     slot;
    miss_ack_i      = 1'b0;
    miss_rtrn_vld_i = 1'b0;
    miss_rtrn_id_i  = '0;
    for (int k = 0; k < MAX_TX; k++) begin
      pend_vld[k] = 1'b0;
    end
    forever begin
      @(posedge clk_i);
      // one return per cycle, the first pending id that is due
      pick = -1;
      for (int k = 0; k < MAX_TX; k++) begin
        if (pend_vld[k]) begin
          if (pend_cnt[k] > 0) pend_cnt[k]--;
          else if (pick < 0) pick = k;
        end
      end
      miss_rtrn_vld_i <= 1'b0;
      if (pick >= 0) begin
        miss_rtrn_vld_i <= 1'b1;
        miss_rtrn_id_i  <= pend_id[pick];
        pend_vld[pick]  = 1'b0;
      end
      if (rst_ni && miss_req_o && miss_ack_i) begin
        slot = -1;
        for (int k = 0; k < MAX_TX; k++) begin
          if (!pend_vld[k] && slot < 0) slot = k;
        end
        pend_vld[slot] = 1'b1;
        pend_id[slot]  = miss_o.id;
        pend_cnt[slot] = $urandom_range(19, 0);
      end
      miss_ack_i <= rst_ni && !silent && ($urandom_range(2, 0) != 0);
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : p_stimulus
    int timer;
    void'($urandom(32'h8e0c));
    aborted    = 1'b0;
    why        = "";
    silent     = 1'b0;
    final_req  = 1'b0;
    rst_ni     = 1'b0;
    wr_valid_i = 1'b0;
    wr_req_i   = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // random traffic with coalescing and rewrites in flight
    for (int n = 0; n < 400; n++) begin
      repeat ($urandom_range(2, 0)) @(posedge clk_i);
      write_word(pool_addr($urandom_range(POOL - 1, 0)));
    end
    // memory silent, walk the whole pool until the buffer fills up
    silent <= 1'b1;
    for (int n = 0; n < POOL; n++) begin
      write_word(pool_addr(n));
    end
    silent <= 1'b0;
    for (int n = 0; n < 200; n++) begin
      repeat ($urandom_range(3, 0)) @(posedge clk_i);
      write_word(pool_addr($urandom_range(POOL - 1, 0)));
    end
    final_req <= 1'b1;
    timer = 0;
    while (!aborted && !report_done && timer < REPORT_TIMEOUT) begin
      @(posedge clk_i);
      timer++;
    end
    if (!aborted && !report_done) begin
      aborted = 1'b1;
      why     = "the checker gave no report before the timeout";
    end
    if (aborted || fail_cnt != 0) begin
      if (aborted) $display("%s", why);
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  end

endmodule

// File: verif/wbuf_checker.sv
/* reference model of the write buffer, follows byte states, ids and the memory image
   at the DUT ports and prints one result line per behavior when the run ends */
module wbuf_checker
  import wbuf_pkg::*;
#(
  parameter int unsigned DEPTH  = 8,
  parameter int unsigned MAX_TX = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wr_valid_i,
  input  wr_req_t   wr_req_i,
  input  logic      wr_gnt_i,
  input  logic      miss_req_i,
  input  miss_req_t miss_i,
  input  logic      miss_ack_i,
  input  logic      miss_rtrn_vld_i,
  input  tx_id_t    miss_rtrn_id_i,
  input  logic      empty_i,
  // stimulus has stopped
  input  logic      final_i,
  output logic      done_o,
  output int        fail_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_WORDS   = 32;
  localparam int RUN_LIMIT   = 200000;
  localparam int DRAIN_LIMIT = 2000;

  // model of every word address seen on the write port
  waddr_t      word_addr [MAX_WORDS];
  int          n_words;
  byte_state_e st   [MAX_WORDS][DATA_BYTES];
  logic [7:0]  cur  [MAX_WORDS][DATA_BYTES];
  logic [7:0]  mem  [MAX_WORDS][DATA_BYTES];
  logic        seen [MAX_WORDS][DATA_BYTES];
  // byte written again while its older value was in flight
  logic        rew  [MAX_WORDS][DATA_BYTES];

  // outstanding ids, out_ret marks an id already returned but not yet retired
  logic        out_vld  [MAX_TX];
  logic        out_ret  [MAX_TX];
  int          out_word [MAX_TX];
  be_t         out_be   [MAX_TX];
  tx_id_t      rtrn_q [$];

  // per behavior: errors and events that exercised it
  int          err  [6];
  int          hits [6];
  string       names [6] = '{"coalescing and final image", "send masks", "transaction ids",
                             "write back-pressure", "rewrite during flight", "drain"};

  function automatic int find_word(waddr_t a);
    for (int w = 0; w < n_words; w++) begin
      if (word_addr[w] == a) return w;
    end
    return -1;
  endfunction

  function automatic be_t bytes_in(int w, byte_state_e s);
    be_t m;
    for (int b = 0; b < DATA_BYTES; b++) begin
      m[b] = (st[w][b] == s);
    end
    return m;
  endfunction

  function automatic be_t flight_bytes(int w);
    return bytes_in(w, byte_inflight) | bytes_in(w, byte_inflight_dirty);
  endfunction

  ////////////////////
  // port compare
  ////////////////////

  // state after the last edge against the DUT levels of this cycle
  task automatic check_ports();
    int   n_valid;
    int   n_out;
    logic hit;
    logic can_send;
    logic exp_val;
    n_valid  = 0;
    n_out    = 0;
    hit      = 1'b0;
    can_send = 1'b0;
    for (int w = 0; w < n_words; w++) begin
      if (bytes_in(w, byte_free) != '1) begin
        n_valid++;
        if (word_addr[w] == wr_req_i.waddr) hit = 1'b1;
      end
      // a word goes out only when none of its bytes is in flight
      if (flight_bytes(w) == '0 && bytes_in(w, byte_dirty) != '0) can_send = 1'b1;
    end
    for (int s = 0; s < MAX_TX; s++) begin
      if (out_vld[s]) n_out++;
    end
    exp_val = (n_valid == 0);
    if (empty_i !== exp_val) begin
      $display("[ERROR] empty_o: got %h, expected %h", empty_i, exp_val);
      err[5]++;
    end
    if (wr_valid_i) begin
      exp_val = hit || (n_valid < DEPTH);
      if (wr_gnt_i !== exp_val) begin
        $display("[ERROR] wr_gnt_o: got %h, expected %h", wr_gnt_i, exp_val);
        err[3]++;
      end
      if (!wr_gnt_i) hits[3]++;
    end
    exp_val = can_send && (n_out < MAX_TX);
    if (miss_req_i !== exp_val) begin
      $display("[ERROR] miss_req_o: got %h, expected %h", miss_req_i, exp_val);
      err[1]++;
    end
  endtask

  ////////////////////
  // model updates
  ////////////////////

  // fifo head retires, one id per edge
  task automatic retire_head();
    tx_id_t id;
    int     w;
    if (rtrn_q.size() != 0) begin
      id = rtrn_q.pop_front();
      w  = out_word[id];
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (out_be[id][b]) begin
          st[w][b] = (st[w][b] == byte_inflight_dirty) ? byte_dirty : byte_free;
        end
      end
      out_vld[id] = 1'b0;
      out_ret[id] = 1'b0;
    end
  endtask

  task automatic apply_send();
    int  w;
    be_t dirty;
    w = find_word(miss_i.waddr);
    hits[1]++;
    hits[2]++;
    if (w < 0) begin
      $display("[ERROR] miss_o.waddr: got %h, a word that was never written", miss_i.waddr);
      err[1]++;
    end else begin
      dirty = bytes_in(w, byte_dirty);
      if (miss_i.be == '0 || (miss_i.be & ~dirty) != '0 || flight_bytes(w) != '0) begin
        $display("[ERROR] miss_o.be: got %h, dirty %h, in flight %h",
                 miss_i.be, dirty, flight_bytes(w));
        err[1]++;
      end
      if (out_vld[miss_i.id]) begin
        $display("[ERROR] miss_o.id: got %h, which is still outstanding", miss_i.id);
        err[2]++;
      end
      out_vld[miss_i.id]  = 1'b1;
      out_ret[miss_i.id]  = 1'b0;
      out_word[miss_i.id] = w;
      out_be[miss_i.id]   = miss_i.be;
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (miss_i.be[b]) begin
          if (miss_i.data[b*8 +: 8] !== cur[w][b]) begin
            $display("[ERROR] miss_o.data byte %0d: got %h, expected %h",
                     b, miss_i.data[b*8 +: 8], cur[w][b]);
            if (rew[w][b]) err[4]++;
            else err[1]++;
          end else if (rew[w][b]) begin
            hits[4]++;
          end
          rew[w][b] = 1'b0;
          mem[w][b] = miss_i.data[b*8 +: 8];
          st[w][b]  = byte_inflight;
        end
      end
    end
  endtask

  task automatic apply_write();
    int w;
    w = find_word(wr_req_i.waddr);
    if (w < 0 && n_words < MAX_WORDS) begin
      w = n_words;
      word_addr[w] = wr_req_i.waddr;
      n_words++;
    end
    hits[0]++;
    if (w >= 0) begin
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (wr_req_i.be[b]) begin
          if (st[w][b] == byte_inflight || st[w][b] == byte_inflight_dirty) begin
            st[w][b]  = byte_inflight_dirty;
            rew[w][b] = 1'b1;
          end else begin
            st[w][b] = byte_dirty;
          end
          cur[w][b]  = wr_req_i.data[b*8 +: 8];
          seen[w][b] = 1'b1;
        end
      end
    end
  endtask

  task automatic take_return();
    if (miss_rtrn_vld_i) begin
      hits[2]++;
      if (!out_vld[miss_rtrn_id_i] || out_ret[miss_rtrn_id_i]) begin
        $display("returned id %0d was not outstanding", miss_rtrn_id_i);
        err[2]++;
      end else begin
        out_ret[miss_rtrn_id_i] = 1'b1;
        rtrn_q.push_back(miss_rtrn_id_i);
      end
    end
  endtask

  // the send sees the state before the edge
  // retire comes before write as in the entries
  // the new return enters the fifo last
  task automatic step_model();
    check_ports();
    if (miss_req_i && miss_ack_i) apply_send();
    retire_head();
    if (wr_valid_i && wr_gnt_i) apply_write();
    take_return();
  endtask

  ////////////////////
  // run and report
  ////////////////////

  initial begin : p_run
    int cyc;
    int passed;
    int failed;
    done_o     = 1'b0;
    fail_cnt_o = 0;
    n_words    = 0;
    passed     = 0;
    failed     = 0;
    for (int t = 0; t < 6; t++) begin
      err[t]  = 0;
      hits[t] = 0;
    end
    for (int w = 0; w < MAX_WORDS; w++) begin
      for (int b = 0; b < DATA_BYTES; b++) begin
        st[w][b]   = byte_free;
        cur[w][b]  = '0;
        mem[w][b]  = '0;
        seen[w][b] = 1'b0;
        rew[w][b]  = 1'b0;
      end
    end
    for (int s = 0; s < MAX_TX; s++) begin
      out_vld[s] = 1'b0;
      out_ret[s] = 1'b0;
    end
    // outputs are stable at the falling edge
    cyc = 0;
    while (!final_i && cyc < RUN_LIMIT) begin
      @(negedge clk_i);
      if (rst_ni) step_model();
      cyc++;
    end
    if (!final_i) begin
      $display("stimulus did not finish within %0d cycles", RUN_LIMIT);
      err[5]++;
    end
    cyc = 0;
    while (!empty_i && cyc < DRAIN_LIMIT) begin
      @(negedge clk_i);
      step_model();
      cyc++;
    end
    if (empty_i) begin
      hits[5]++;
    end else begin
      $display("buffer did not drain within %0d cycles", DRAIN_LIMIT);
      err[5]++;
    end
    // memory must hold the newest value of every byte ever written
    for (int w = 0; w < n_words; w++) begin
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (seen[w][b] && mem[w][b] !== cur[w][b]) begin
          $display("[ERROR] memory word %h byte %0d: got %h, expected %h",
                   word_addr[w], b, mem[w][b], cur[w][b]);
          err[0]++;
        end
      end
    end
    for (int t = 0; t < 6; t++) begin
      if (err[t] == 0 && hits[t] > 0) passed++;
      else failed++;
      $display("test %0d %s: %s, %0d events, %0d errors", t + 1, names[t],
               (err[t] == 0 && hits[t] > 0) ? "pass" : "FAIL", hits[t], err[t]);
    end
    $display("summary: %0d tests passed, %0d tests failed", passed, failed);
    fail_cnt_o = failed;
    done_o     = 1'b1;
  end

endmodule

// File: verilog/wbuf_top.sv
/* top level of the coalescing store write buffer
   core writes in at the wr_ ports, memory writes out at the miss_ ports */
module wbuf_top
  import wbuf_pkg::*;
#(
  parameter int unsigned DEPTH  = 8,
  parameter int unsigned MAX_TX = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // core write port
  input  logic      wr_valid_i,
  input  wr_req_t   wr_req_i,
  output logic      wr_gnt_o,
  // memory write request
  output logic      miss_req_o,
  output miss_req_t miss_o,
  input  logic      miss_ack_i,
  // memory write ack
  input  logic      miss_rtrn_vld_i,
  input  tx_id_t    miss_rtrn_id_i,
  // no valid byte left
  output logic      empty_o
);

  // entry status
  waddr_t [DEPTH-1:0] entry_tag;
  data_t  [DEPTH-1:0] entry_data;
  logic   [DEPTH-1:0] entry_vld;
  be_t    [DEPTH-1:0] entry_sendable;

  // entry updates
  logic   [DEPTH-1:0] wr_en;
  logic   [DEPTH-1:0] send;
  be_t                send_be;
  logic   [DEPTH-1:0] retire;
  be_t                retire_be;

  // returned ids
  tx_id_t             rtrn_id;
  logic               rtrn_vld;
  logic               rtrn_pop;

  // ids must fit the id field
  if (MAX_TX > (1 << TX_ID_W)) begin : gen_tx_check
    $fatal(1, "MAX_TX does not fit into TX_ID_W bits");
  end

  assign empty_o = ~|entry_vld;

  ////////////////////
  // write side
  ////////////////////

  wbuf_alloc #(
    .DEPTH(DEPTH)
  ) i_wbuf_alloc (
    .wr_valid_i (wr_valid_i),
    .wr_req_i   (wr_req_i),
    .entry_tag_i(entry_tag),
    .entry_vld_i(entry_vld),
    .wr_gnt_o   (wr_gnt_o),
    .wr_en_o    (wr_en)
  );

  // every entry sees the same request, wr_en picks the one that stores it
  for (genvar k = 0; k < DEPTH; k++) begin : gen_entry
    wbuf_entry i_wbuf_entry (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .wr_en_i    (wr_en[k]),
      .wr_req_i   (wr_req_i),
      .send_i     (send[k]),
      .send_be_i  (send_be),
      .retire_i   (retire[k]),
      .retire_be_i(retire_be),
      .tag_o      (entry_tag[k]),
      .data_o     (entry_data[k]),
      .vld_o      (entry_vld[k]),
      .sendable_o (entry_sendable[k])
    );
  end

  ////////////////////
  // drain side
  ////////////////////

  wbuf_drain #(
    .DEPTH (DEPTH),
    .MAX_TX(MAX_TX)
  ) i_wbuf_drain (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sendable_i (entry_sendable),
    .tag_i      (entry_tag),
    .data_i     (entry_data),
    .miss_req_o (miss_req_o),
    .miss_o     (miss_o),
    .miss_ack_i (miss_ack_i),
    .send_o     (send),
    .send_be_o  (send_be),
    .rtrn_vld_i (rtrn_vld),
    .rtrn_id_i  (rtrn_id),
    .rtrn_pop_o (rtrn_pop),
    .retire_o   (retire),
    .retire_be_o(retire_be)
  );

  wbuf_rtrn_fifo #(
    .MAX_TX(MAX_TX)
  ) i_wbuf_rtrn_fifo (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .push_i(miss_rtrn_vld_i),
    .id_i  (miss_rtrn_id_i),
    .pop_i (rtrn_pop),
    .id_o  (rtrn_id),
    .vld_o (rtrn_vld)
  );

endmodule

// File: verilog/wbuf_rtrn_fifo.sv
/* registered fifo of returned transaction ids
   an id pushed in one cycle is visible at the output in the next */
module wbuf_rtrn_fifo
  import wbuf_pkg::*;
#(
  parameter int unsigned MAX_TX = 4
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  // from memory
  input  logic   push_i,
  input  tx_id_t id_i,
  // to the drain
  input  logic   pop_i,
  output tx_id_t id_o,
  output logic   vld_o
);

  localparam int unsigned PTR_W = (MAX_TX > 1) ? $clog2(MAX_TX) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_TX + 1);

  tx_id_t           mem_q [MAX_TX];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // wrap at MAX_TX which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(MAX_TX - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (cnt_q == CNT_W'(MAX_TX));
  assign vld_o   = (cnt_q != '0);
  assign id_o    = mem_q[rd_ptr_q];
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && vld_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptrs
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // id storage
  always_ff @(posedge clk_i) begin : p_mem
    if (do_push) begin
      mem_q[wr_ptr_q] <= id_i;
    end
  end

  // at most MAX_TX ids are ever outstanding
  // so a full fifo means memory returned an id twice
  no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full)
  else $error("returned id pushed into a full fifo");

endmodule

// File: verilog/wbuf_drain.sv
/* drain side of the buffer, picks a sendable entry round-robin and tags it with an id
   keeps the transaction slot table and retires returned ids into the entries */
module wbuf_drain
  import wbuf_pkg::*;
#(
  parameter int unsigned DEPTH  = 8,
  parameter int unsigned MAX_TX = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // entry status
  input  be_t    [DEPTH-1:0] sendable_i,
  input  waddr_t [DEPTH-1:0] tag_i,
  input  data_t  [DEPTH-1:0] data_i,
  // memory write request
  output logic               miss_req_o,
  output miss_req_t          miss_o,
  input  logic               miss_ack_i,
  // byte update on send
  output logic   [DEPTH-1:0] send_o,
  output be_t                send_be_o,
  // returned ids from the fifo
  input  logic               rtrn_vld_i,
  input  tx_id_t             rtrn_id_i,
  output logic               rtrn_pop_o,
  // byte update on retire
  output logic   [DEPTH-1:0] retire_o,
  output be_t                retire_be_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  // entry and sent mask of one outstanding id
  typedef struct packed {
    ptr_t ptr;
    be_t  be;
  } tx_slot_t;

  logic     [MAX_TX-1:0] tx_vld_q;
  tx_slot_t [MAX_TX-1:0] tx_slot_q;
  logic     [DEPTH-1:0]  has_dirty;
  ptr_t                  rr_q;
  ptr_t                  rr_pick;
  ptr_t                  sel_q;
  ptr_t                  sel;
  tx_id_t                id_q;
  tx_id_t                free_id;
  tx_id_t                tx_id;
  logic                  lock_q;
  logic                  free_slot;
  logic                  accept;

  ////////////////////
  // entry select
  ////////////////////

  always_comb begin : p_has_dirty
    for (int k = 0; k < DEPTH; k++) begin
      has_dirty[k] = |sendable_i[k];
    end
  end

  // search starts after the last served entry
  // loop runs backwards so the nearest candidate wins
  always_comb begin : p_rr_pick
    int unsigned idx;
    rr_pick = rr_q;
    for (int i = DEPTH; i >= 1; i--) begin
      idx = (int'(rr_q) + i) % DEPTH;
      if (has_dirty[idx]) begin
        rr_pick = ptr_t'(idx);
      end
    end
  end

  // lowest free slot becomes the id
  always_comb begin : p_free_id
    free_id = '0;
    for (int s = MAX_TX - 1; s >= 0; s--) begin
      if (!tx_vld_q[s]) begin
        free_id = tx_id_t'(s);
      end
    end
  end

  assign free_slot = ~&tx_vld_q;

  // entry and id are held while memory stalls
  // the locked entry keeps its sendable bytes and the locked slot stays free
  assign sel   = lock_q ? sel_q : rr_pick;
  assign tx_id = lock_q ? id_q : free_id;

  ////////////////////
  // request
  ////////////////////

  assign miss_req_o = (|has_dirty) && free_slot;
  assign accept     = miss_req_o && miss_ack_i;

  // mask and data follow writes that coalesce into the locked entry
  assign miss_o.waddr = tag_i[sel];
  assign miss_o.data  = data_i[sel];
  assign miss_o.be    = sendable_i[sel];
  assign miss_o.id    = tx_id;

  assign send_be_o = sendable_i[sel];

  ////////////////////
  // retire
  ////////////////////

  // no cache to update so a returned id retires at once
  assign rtrn_pop_o  = rtrn_vld_i;
  assign retire_be_o = tx_slot_q[rtrn_id_i].be;

  always_comb begin : p_onehot
    send_o   = '0;
    retire_o = '0;
    if (accept) begin
      send_o[sel] = 1'b1;
    end
    if (rtrn_vld_i) begin
      retire_o[tx_slot_q[rtrn_id_i].ptr] = 1'b1;
    end
  end

  ////////////////////
  // state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      tx_vld_q <= '0;
      rr_q     <= ptr_t'(DEPTH - 1);
      sel_q    <= '0;
      id_q     <= '0;
      lock_q   <= 1'b0;
    end else begin
      lock_q <= miss_req_o && !miss_ack_i;
      sel_q  <= sel;
      id_q   <= tx_id;
      if (accept) begin
        rr_q            <= sel;
        tx_vld_q[tx_id] <= 1'b1;
      end
      if (rtrn_vld_i) begin
        tx_vld_q[rtrn_id_i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_slot
    if (accept) begin
      tx_slot_q[tx_id] <= '{ptr: sel, be: sendable_i[sel]};
    end
  end

  // a returned id was handed out earlier and is still open
  tx_alloc_retire : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && rtrn_vld_i |-> (tx_id != rtrn_id_i))
  else $error("same transaction slot allocated and retired in one cycle");

  tx_retire_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rtrn_vld_i |-> tx_vld_q[rtrn_id_i])
  else $error("retiring a transaction slot that is not outstanding");

endmodule

// File: verilog/wbuf_entry.sv
/* one buffer entry with word tag, data and a state per byte
   written by the allocator, sent and retired by the drain */
module wbuf_entry
  import wbuf_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  // core write into this entry
  input  logic    wr_en_i,
  input  wr_req_t wr_req_i,
  // bytes leaving as a transaction
  input  logic    send_i,
  input  be_t     send_be_i,
  // bytes acknowledged by memory
  input  logic    retire_i,
  input  be_t     retire_be_i,
  // entry status
  output waddr_t  tag_o,
  output data_t   data_o,
  output logic    vld_o,
  output be_t     sendable_o
);

  waddr_t      tag_q;
  data_t       data_q;
  byte_state_e state_q [DATA_BYTES];
  byte_state_e state_d [DATA_BYTES];
  be_t         dirty_mask;
  be_t         flight_mask;
  be_t         used_mask;

  ////////////////////
  // status
  ////////////////////

  always_comb begin : p_masks
    for (int b = 0; b < DATA_BYTES; b++) begin
      dirty_mask[b]  = (state_q[b] == byte_dirty);
      flight_mask[b] = (state_q[b] == byte_inflight) ||
                       (state_q[b] == byte_inflight_dirty);
      used_mask[b]   = (state_q[b] != byte_free);
    end
  end

  assign tag_o  = tag_q;
  assign data_o = data_q;
  assign vld_o  = |used_mask;

  // nothing goes out while part of the word is in flight
  // two writes to one word could otherwise overtake each other in memory
  assign sendable_o = (|flight_mask) ? '0 : dirty_mask;

  ////////////////////
  // byte states
  ////////////////////

  // retire first, then send, then write
  // send and retire never hit the same entry in one cycle
  always_comb begin : p_next_state
    for (int b = 0; b < DATA_BYTES; b++) begin
      state_d[b] = state_q[b];
      // ack returned
      if (retire_i && retire_be_i[b]) begin
        state_d[b] = (state_q[b] == byte_inflight_dirty) ? byte_dirty : byte_free;
      end
      // handed to memory
      if (send_i && send_be_i[b]) begin
        state_d[b] = byte_inflight;
      end
      // rewritten while in flight keeps the flight marker
      if (wr_en_i && wr_req_i.be[b]) begin
        state_d[b] = ((state_d[b] == byte_inflight) ||
                      (state_d[b] == byte_inflight_dirty)) ?
                     byte_inflight_dirty : byte_dirty;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= '{default: byte_free};
    end else begin
      state_q <= state_d;
    end
  end

  // tag and data
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_en_i) begin
      tag_q <= wr_req_i.waddr;
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (wr_req_i.be[b]) begin
          data_q[b*8 +: 8] <= wr_req_i.data[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // the drain only sends what this entry reported as sendable
  send_dirty_only : assert property (@(posedge clk_i) disable iff (!rst_ni)
    send_i |-> ((send_be_i & ~dirty_mask) == '0))
  else $error("entry sends a byte that is not dirty");

  // the slot table mask must still match bytes that are out
  retire_flight_only : assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_i |-> ((retire_be_i & ~flight_mask) == '0))
  else $error("entry retires a byte that is not in flight");

endmodule

// File: verilog/wbuf_alloc.sv
/* write allocation of the buffer, matches a core write against buffered words
   and picks the entry that takes it, purely combinational */
module wbuf_alloc
  import wbuf_pkg::*;
#(
  parameter int unsigned DEPTH = 8
) (
  // core write
  input  logic               wr_valid_i,
  input  wr_req_t            wr_req_i,
  // entry status
  input  waddr_t [DEPTH-1:0] entry_tag_i,
  input  logic   [DEPTH-1:0] entry_vld_i,
  // grant and entry select
  output logic               wr_gnt_o,
  output logic   [DEPTH-1:0] wr_en_o
);

  logic [DEPTH-1:0] hit;
  logic [DEPTH-1:0] free_oh;
  logic             any_hit;
  logic             any_free;

  ////////////////////
  // word match
  ////////////////////

  // only entries holding a valid byte take part in the compare
  // stale tags of free entries never match
  always_comb begin : p_match
    for (int k = 0; k < DEPTH; k++) begin
      hit[k] = entry_vld_i[k] && (entry_tag_i[k] == wr_req_i.waddr);
    end
  end

  assign any_hit = |hit;

  ////////////////////
  // free entry
  ////////////////////

  // lowest clear bit of the valid vector
  // all ones gives zero here
  assign free_oh  = ~entry_vld_i & (entry_vld_i + DEPTH'(1));
  assign any_free = |free_oh;

  ////////////////////
  // grant
  ////////////////////

  // grant does not look at wr_valid_i
  // so it is already high when the core raises a request
  assign wr_gnt_o = any_hit || any_free;

  // coalesce into the matching word first
  // a new word only when nothing matches
  always_comb begin : p_wr_en
    wr_en_o = '0;
    if (wr_valid_i) begin
      wr_en_o = any_hit ? hit : free_oh;
    end
  end

  // a word lives in one entry only
  // relies on the entries never taking a second copy of a buffered word
  always_comb begin : p_hit_check
    if (wr_valid_i) begin
      assert final ($onehot0(hit))
      else $error("write address matches more than one buffer entry");
    end
  end

endmodule

// File: verilog/wbuf_pkg.sv
/* widths, request structs and byte state encoding of the coalescing write buffer
   every buffer module takes these by a wildcard import */
package wbuf_pkg;

  ////////////////////
  // widths
  ////////////////////

  // bytes in one data word
  localparam int unsigned DATA_BYTES = 8;

  // transaction id width
  // the top level MAX_TX must fit into 2**TX_ID_W ids
  localparam int unsigned TX_ID_W = 2;

  // word address without the byte offset bits
  localparam int unsigned WADDR_W = 29;

  ////////////////////
  // basic types
  ////////////////////

  typedef logic [WADDR_W-1:0]      waddr_t;
  typedef logic [DATA_BYTES*8-1:0] data_t;
  typedef logic [DATA_BYTES-1:0]   be_t;
  typedef logic [TX_ID_W-1:0]      tx_id_t;

  // state of one buffered byte
  typedef enum logic [1:0] {
    // not in use
    byte_free,
    // written and waiting to be sent
    byte_dirty,
    // sent and waiting for the memory ack
    byte_inflight,
    // sent and then written again
    byte_inflight_dirty
  } byte_state_e;

  ////////////////////
  // request structs
  ////////////////////

  // one core write with byte enables
  typedef struct packed {
    waddr_t waddr;
    data_t  data;
    be_t    be;
  } wr_req_t;

  // one outgoing memory write
  // be holds the dirty bytes that this transaction carries
  typedef struct packed {
    waddr_t waddr;
    data_t  data;
    be_t    be;
    tx_id_t id;
  } miss_req_t;

endpackage
